// ==== nnAccelerator.f ====
+incdir+verilog
verilog/nnBusPkg.sv
verilog/nnMathPkg.sv
verilog/nnRegFile.sv
verilog/operandFetch.sv
verilog/operandFifo.sv
verilog/macArray.sv
verilog/nnAccelerator.sv
bench/nnAcceleratorTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert \
		-f nnAccelerator.f --top-module nnAcceleratorTb -Mdir obj_dir \
	&& ./obj_dir/VnnAcceleratorTb \
	|| exit 1

// ==== bench/nnAcceleratorTb.sv ====
`default_nettype none

`include "nn_defines.svh"

module nnAcceleratorTb;
	timeunit 1ns;
	timeprecision 1ps;

	import nnBusPkg::*;
	import nnMathPkg::*;

	localparam int HalfPeriod = 5;
	localparam int ClockPeriod = 2 * HalfPeriod;
	localparam int ResetCycles = 10;
	localparam int Trials = 8;
	localparam int CyclesPerTrial = 400;
	localparam int WatchdogTime = Trials * CyclesPerTrial * ClockPeriod;
	localparam int PollLimit = 200;

	bit CLOCK1_50;
	bit resetHidden;
	bit busWrite;
	regSelect busSel;
	neuronIndex busNeuron;
	busAddr busIndex;
	busWord busWriteData;
	busWord busReadData;

	// Reference model state
	operandWord inputVec [`INPUT_LEN];
	operandWord hiddenWeights [`HIDDEN_N][`INPUT_LEN];
	operandWord outInputVec [`HIDDEN_N];
	operandWord outWeights [`OUTPUT_N][`HIDDEN_N];
	accumWord expHidden [`HIDDEN_N];
	accumWord expOutput [`OUTPUT_N];
	bit expOutputDone;
	integer seed;
	int errorCount;

	nnAccelerator dut (
		.CLOCK1_50(CLOCK1_50),
		.resetHidden(resetHidden),
		.busWrite(busWrite),
		.busSel(busSel),
		.busNeuron(busNeuron),
		.busAddr(busIndex),
		.busWriteData(busWriteData),
		.busReadData(busReadData)
	);

	always #HalfPeriod CLOCK1_50 = ~CLOCK1_50;

	////////////////////
	// Failure handling
	////////////////////

	task automatic stopRun();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkWord(input string name, input busWord got, input busWord expected);
		if (got !== expected) begin
			errorCount++;
			$display("FAIL %0t ns %s: got %h, expected %h", $time, name, got, expected);
			stopRun();
		end
	endtask

	task automatic checkAccum(input string name, input accumWord got, input accumWord expected);
		if (got !== expected) begin
			errorCount++;
			$display("FAIL %0t ns %s: got %0d, expected %0d", $time, name, got, expected);
			stopRun();
		end
	endtask

	task automatic checkStatus(input string name, input statusWord got,
		input statusWord expected);
		if (got !== expected) begin
			errorCount++;
			$display("FAIL %0t ns %s: got %h, expected %h", $time, name, got, expected);
			stopRun();
		end
	endtask

	initial begin
		#(WatchdogTime);
		$display("Watchdog expired before all trials finished");
		stopRun();
	end

	////////////////////
	// Bus access
	////////////////////

	function automatic busWord randomWord();
		busWord value;
		value = $random(seed);
		return value;
	endfunction

	function automatic accumWord productOf(input operandWord a, input operandWord b);
		// Full product fits in 32 bits, the sum then wraps
		return accumWord'(a) * accumWord'(b);
	endfunction

	// Leaves busWrite high so bursts take one cycle per element
	task automatic writeWord(input regSelect sel, input neuronIndex neuron, input busAddr addr,
		input busWord data);
		@(negedge CLOCK1_50);
		busWrite = 1'b1;
		busSel = sel;
		busNeuron = neuron;
		busIndex = addr;
		busWriteData = data;
	endtask

	task automatic busIdle();
		@(negedge CLOCK1_50);
		busWrite = 1'b0;
		busSel = SEL_STATUS;
	endtask

	// Data shows up one cycle after the request
	task automatic readWord(input regSelect sel, input busAddr addr, output busWord data);
		@(negedge CLOCK1_50);
		busWrite = 1'b0;
		busSel = sel;
		busIndex = addr;
		@(negedge CLOCK1_50);
		data = busReadData;
	endtask

	task automatic checkReadback(input regSelect sel, input busAddr addr);
		busWord data;
		busWord got;
		busWord expected;
		data = randomWord();
		expected = {{(`ACCUM_W - `OPERAND_W){data[`OPERAND_W-1]}}, data[`OPERAND_W-1:0]};
		writeWord(sel, '0, addr, data);
		readWord(sel, addr, got);
		checkWord($sformatf("%s[%0d]", sel.name(), addr), got, expected);
	endtask

	task automatic expectStatus(input string name, input bit hiddenDone, input bit outputDone);
		busWord data;
		statusWord expected;
		expected = '0;
		expected.hiddenDone = hiddenDone;
		expected.outputDone = outputDone;
		readWord(SEL_STATUS, '0, data);
		checkStatus(name, statusWord'(data), expected);
	endtask

	task automatic checkHiddenResults(input bit expectZero);
		busWord data;
		for (int n = 0; n < `HIDDEN_N; n++) begin
			readWord(SEL_HIDDEN_RESULT, busAddr'(n), data);
			checkAccum($sformatf("hiddenResult[%0d]", n), accumWord'(data),
				expectZero ? accumWord'(0) : expHidden[n]);
		end
	endtask

	task automatic checkOutputResults(input bit expectZero);
		busWord data;
		for (int n = 0; n < `OUTPUT_N; n++) begin
			readWord(SEL_OUTPUT_RESULT, busAddr'(n), data);
			checkAccum($sformatf("outputResult[%0d]", n), accumWord'(data),
				expectZero ? accumWord'(0) : expOutput[n]);
		end
	endtask

	task automatic waitForDone(input layerSel layer, input string what);
		busWord data;
		statusWord status;
		int polls;
		polls = 0;
		status = '0;
		while (!((layer == LAYER_HIDDEN) ? status.hiddenDone : status.outputDone)) begin
			if (polls == PollLimit) begin
				$display("The %s pass never raised its done bit", what);
				stopRun();
			end
			readWord(SEL_STATUS, '0, data);
			status = statusWord'(data);
			polls++;
		end
	endtask

	////////////////////
	// Layer passes
	////////////////////

	task automatic runHiddenLayer();
		busWord data;
		for (int n = 0; n < `HIDDEN_N; n++) begin
			for (int k = 0; k < `INPUT_LEN; k++) begin
				data = randomWord();
				hiddenWeights[n][k] = operandWord'(data[`OPERAND_W-1:0]);
				writeWord(SEL_HIDDEN_WEIGHT, neuronIndex'(n), busAddr'(k), data);
			end
		end
		// Element 0 alone, so the clear can be seen
		data = randomWord();
		inputVec[0] = operandWord'(data[`OPERAND_W-1:0]);
		writeWord(SEL_INPUT, '0, '0, data);
		busIdle();
		expectStatus("status after hidden clear", 1'b0, expOutputDone);
		checkHiddenResults(1'b1);
		for (int k = 1; k < `INPUT_LEN; k++) begin
			data = randomWord();
			inputVec[k] = operandWord'(data[`OPERAND_W-1:0]);
			writeWord(SEL_INPUT, '0, busAddr'(k), data);
		end
		busIdle();
		for (int n = 0; n < `HIDDEN_N; n++) begin
			expHidden[n] = '0;
			for (int k = 0; k < `INPUT_LEN; k++)
				expHidden[n] = expHidden[n] + productOf(inputVec[k], hiddenWeights[n][k]);
		end
		waitForDone(LAYER_HIDDEN, "hidden");
		expectStatus("status after hidden pass", 1'b1, expOutputDone);
		checkHiddenResults(1'b0);
	endtask

	task automatic runOutputLayer();
		busWord data;
		for (int n = 0; n < `OUTPUT_N; n++) begin
			for (int k = 0; k < `HIDDEN_N; k++) begin
				data = randomWord();
				outWeights[n][k] = operandWord'(data[`OPERAND_W-1:0]);
				writeWord(SEL_OUTPUT_WEIGHT, neuronIndex'(n), busAddr'(k), data);
			end
		end
		// Hidden results fed back, DUT keeps the low bits
		for (int k = 0; k < `HIDDEN_N; k++)
			outInputVec[k] = operandWord'(expHidden[k][`OPERAND_W-1:0]);
		writeWord(SEL_OUTPUT_INPUT, '0, '0, busWord'(expHidden[0]));
		busIdle();
		expectStatus("status after output clear", 1'b1, 1'b0);
		checkOutputResults(1'b1);
		for (int k = 1; k < `HIDDEN_N; k++)
			writeWord(SEL_OUTPUT_INPUT, '0, busAddr'(k), busWord'(expHidden[k]));
		busIdle();
		for (int n = 0; n < `OUTPUT_N; n++) begin
			expOutput[n] = '0;
			for (int k = 0; k < `HIDDEN_N; k++)
				expOutput[n] = expOutput[n] + productOf(outInputVec[k], outWeights[n][k]);
		end
		expOutputDone = 1'b1;
		waitForDone(LAYER_OUTPUT, "output");
		expectStatus("status after output pass", 1'b1, 1'b1);
		checkOutputResults(1'b0);
		checkHiddenResults(1'b0);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		seed = 40817;
		errorCount = 0;
		expOutputDone = 1'b0;
		resetHidden = 1'b1;
		busWrite = 1'b0;
		busSel = SEL_STATUS;
		busNeuron = '0;
		busIndex = '0;
		busWriteData = '0;
		repeat (ResetCycles) @(negedge CLOCK1_50);
		resetHidden = 1'b0;

		expectStatus("status after reset", 1'b0, 1'b0);
		checkHiddenResults(1'b1);
		checkOutputResults(1'b1);

		for (int trial = 0; trial < Trials; trial++) begin
			// Addresses that neither clear nor start a pass
			checkReadback(SEL_INPUT, busAddr'(1 + ({$random(seed)} % (`INPUT_LEN - 2))));
			checkReadback(SEL_OUTPUT_INPUT, busAddr'(1 + ({$random(seed)} % (`HIDDEN_N - 2))));
			runHiddenLayer();
			runOutputLayer();
		end

		if (errorCount == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			stopRun();
		end
	end

endmodule

`default_nettype wire

// ==== verilog/nnAccelerator.sv ====
`default_nettype none

`include "nn_defines.svh"

module nnAccelerator (
	input  bit                   CLOCK1_50,
	input  bit                   resetHidden,
	input  bit                   busWrite,
	input  nnBusPkg::regSelect   busSel,
	input  nnBusPkg::neuronIndex busNeuron,
	input  nnBusPkg::busAddr     busAddr,
	input  nnBusPkg::busWord     busWriteData,
	output nnBusPkg::busWord     busReadData
);
	import nnMathPkg::*;

	// Start and clear pulses
	logic hiddenStart;
	logic outputStart;
	logic hiddenClear;
	logic outputClear;

	// Fetch port
	layerSel fetchLayer;
	nnBusPkg::busAddr fetchIndex;
	operandWord fetchInput;
	operandWord fetchWeights [`HIDDEN_N];

	// Sequencer to FIFO
	logic beatValid;
	logic beatReady;
	operandWord beatInput;
	operandWord beatWeights [`HIDDEN_N];
	layerSel beatLayer;
	logic beatLast;

	// FIFO to MAC bank
	logic macValid;
	logic macReady;
	operandWord macInput;
	operandWord macWeights [`HIDDEN_N];
	layerSel macLayer;
	logic macLast;

	// Results back to the bus
	accumWord hiddenResults [`HIDDEN_N];
	accumWord outputResults [`OUTPUT_N];
	logic hiddenDone;
	logic outputDone;

	// Signal names match the block ports one to one
	nnRegFile regFile (.*);

	operandFetch fetch (.*);

	operandFifo fifo (.*);

	macArray macs (.*);

endmodule

`default_nettype wire

// ==== verilog/macArray.sv ====
`default_nettype none

`include "nn_defines.svh"

module macArray (
	input  bit                    CLOCK1_50,
	input  bit                    resetHidden,
	input  logic                  hiddenClear,
	input  logic                  outputClear,
	input  logic                  macValid,
	output logic                  macReady,
	input  nnMathPkg::operandWord macInput,
	input  nnMathPkg::operandWord macWeights [`HIDDEN_N],
	input  nnMathPkg::layerSel    macLayer,
	input  logic                  macLast,
	output nnMathPkg::accumWord   hiddenResults [`HIDDEN_N],
	output nnMathPkg::accumWord   outputResults [`OUTPUT_N],
	output logic                  hiddenDone,
	output logic                  outputDone
);
	import nnMathPkg::*;

	accumWord accum [`HIDDEN_N];
	accumWord laneSum [`HIDDEN_N];
	logic signed [2*`OPERAND_W-1:0] product [`HIDDEN_N];
	logic accept;
	// High for the cycle after a last beat
	logic drain;
	logic passActive;
	layerSel passLayer;

	assign macReady = !drain;
	assign accept = macValid && macReady;

	// Signed product, sign-extended into the sum
	for (genvar n = 0; n < `HIDDEN_N; n++) begin : gLane
		assign product[n] = (2*`OPERAND_W)'(macInput) * (2*`OPERAND_W)'(macWeights[n]);
		assign laneSum[n] = accum[n] + accumWord'(product[n]);
	end

	always_ff @(posedge CLOCK1_50) begin
		for (int n = 0; n < `HIDDEN_N; n++) begin
			if (resetHidden || drain)
				accum[n] <= '0;
			else if (accept)
				accum[n] <= laneSum[n];
		end
	end

	////////////////////
	// Results and done flags
	////////////////////

	always_ff @(posedge CLOCK1_50) begin
		if (resetHidden) begin
			drain <= 1'b0;
			hiddenDone <= 1'b0;
			outputDone <= 1'b0;
			for (int n = 0; n < `HIDDEN_N; n++)
				hiddenResults[n] <= '0;
			for (int n = 0; n < `OUTPUT_N; n++)
				outputResults[n] <= '0;
		end else begin
			drain <= accept && macLast;
			if (accept && macLast) begin
				if (macLayer == LAYER_HIDDEN) begin
					for (int n = 0; n < `HIDDEN_N; n++)
						hiddenResults[n] <= laneSum[n];
					hiddenDone <= 1'b1;
				end else begin
					// Upper lanes carry zero weights in this layer
					for (int n = 0; n < `OUTPUT_N; n++)
						outputResults[n] <= laneSum[n];
					outputDone <= 1'b1;
				end
			end
			if (hiddenClear) begin
				for (int n = 0; n < `HIDDEN_N; n++)
					hiddenResults[n] <= '0;
				hiddenDone <= 1'b0;
			end
			if (outputClear) begin
				for (int n = 0; n < `OUTPUT_N; n++)
					outputResults[n] <= '0;
				outputDone <= 1'b0;
			end
		end
	end

	// Layer of the pass in flight
	always_ff @(posedge CLOCK1_50) begin
		if (resetHidden) begin
			passActive <= 1'b0;
			passLayer <= LAYER_HIDDEN;
		end else if (accept) begin
			passActive <= !macLast;
			passLayer <= macLayer;
		end
	end

	assert property (@(posedge CLOCK1_50) disable iff (resetHidden)
		macValid && passActive |-> macLayer == passLayer);

endmodule

`default_nettype wire

// ==== verilog/operandFifo.sv ====
`default_nettype none

`include "nn_defines.svh"

module operandFifo (
	input  bit                    CLOCK1_50,
	input  bit                    resetHidden,
	input  logic                  beatValid,
	output logic                  beatReady,
	input  nnMathPkg::operandWord beatInput,
	input  nnMathPkg::operandWord beatWeights [`HIDDEN_N],
	input  nnMathPkg::layerSel    beatLayer,
	input  logic                  beatLast,
	output logic                  macValid,
	input  logic                  macReady,
	output nnMathPkg::operandWord macInput,
	output nnMathPkg::operandWord macWeights [`HIDDEN_N],
	output nnMathPkg::layerSel    macLayer,
	output logic                  macLast
);
	import nnMathPkg::*;

	localparam int PtrW = $clog2(`FIFO_DEPTH);
	localparam int CountW = $clog2(`FIFO_DEPTH + 1);

	operandWord inputStore [`FIFO_DEPTH];
	operandWord weightStore [`FIFO_DEPTH][`HIDDEN_N];
	layerSel layerStore [`FIFO_DEPTH];
	logic lastStore [`FIFO_DEPTH];

	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CountW-1:0] count;
	logic full;
	logic empty;
	logic push;
	logic pop;

	assign full = count == CountW'(`FIFO_DEPTH);
	assign empty = count == '0;
	assign beatReady = !full;
	assign macValid = !empty;
	assign push = beatValid && beatReady;
	assign pop = macValid && macReady;

	// Whole beats
	always_ff @(posedge CLOCK1_50) begin
		if (push) begin
			inputStore[wrPtr] <= beatInput;
			weightStore[wrPtr] <= beatWeights;
			layerStore[wrPtr] <= beatLayer;
			lastStore[wrPtr] <= beatLast;
		end
	end

	always_ff @(posedge CLOCK1_50) begin
		if (resetHidden) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= wrPtr + PtrW'(1);
			if (pop)
				rdPtr <= rdPtr + PtrW'(1);
			case ({push, pop})
				2'b10: count <= count + CountW'(1);
				2'b01: count <= count - CountW'(1);
				default: ;
			endcase
		end
	end

	assign macInput = inputStore[rdPtr];
	assign macWeights = weightStore[rdPtr];
	assign macLayer = layerStore[rdPtr];
	assign macLast = lastStore[rdPtr];

	// Full FIFO has the write pointer back on the oldest beat
	assert property (@(posedge CLOCK1_50) disable iff (resetHidden)
		full |-> wrPtr == rdPtr);

	// Empty FIFO has both pointers on the next free slot
	assert property (@(posedge CLOCK1_50) disable iff (resetHidden)
		empty |-> wrPtr == rdPtr);

endmodule

`default_nettype wire

// ==== verilog/operandFetch.sv ====
`default_nettype none

`include "nn_defines.svh"

module operandFetch (
	input  bit                    CLOCK1_50,
	input  bit                    resetHidden,
	input  logic                  hiddenStart,
	input  logic                  outputStart,
	output nnMathPkg::layerSel    fetchLayer,
	output nnBusPkg::busAddr      fetchIndex,
	input  nnMathPkg::operandWord fetchInput,
	input  nnMathPkg::operandWord fetchWeights [`HIDDEN_N],
	output logic                  beatValid,
	input  logic                  beatReady,
	output nnMathPkg::operandWord beatInput,
	output nnMathPkg::operandWord beatWeights [`HIDDEN_N],
	output nnMathPkg::layerSel    beatLayer,
	output logic                  beatLast
);
	import nnBusPkg::*;
	import nnMathPkg::*;

	fetchState state;
	layerSel activeLayer;
	busAddr index;
	busAddr lastIndex;
	logic transfer;

	assign lastIndex = (activeLayer == LAYER_HIDDEN) ?
		`ADDR_W'(`INPUT_LEN - 1) : `ADDR_W'(`HIDDEN_N - 1);
	assign transfer = beatValid && beatReady;

	////////////////////
	// Sequencer FSM
	////////////////////

	always_ff @(posedge CLOCK1_50) begin
		if (resetHidden) begin
			state <= FETCH_IDLE;
			activeLayer <= LAYER_HIDDEN;
			index <= '0;
		end else begin
			case (state)
				FETCH_IDLE: begin
					if (hiddenStart || outputStart) begin
						state <= FETCH_RUN;
						activeLayer <= hiddenStart ? LAYER_HIDDEN : LAYER_OUTPUT;
						index <= '0;
					end
				end
				// Starts during a pass are dropped here
				FETCH_RUN: begin
					if (transfer) begin
						index <= index + busAddr'(1);
						if (beatLast)
							state <= FETCH_IDLE;
					end
				end
				default: state <= FETCH_IDLE;
			endcase
		end
	end

	// Beat comes straight from the memories at the current index
	assign fetchLayer = activeLayer;
	assign fetchIndex = index;
	assign beatValid = state == FETCH_RUN;
	assign beatInput = fetchInput;
	assign beatWeights = fetchWeights;
	assign beatLayer = activeLayer;
	assign beatLast = index == lastIndex;

	// Stalled beat holds, so the memories must not move under it
	assert property (@(posedge CLOCK1_50) disable iff (resetHidden)
		beatValid && !beatReady |=> beatValid && $stable(beatInput) &&
			$stable(beatLayer) && $stable(beatLast));

endmodule

`default_nettype wire

// ==== verilog/nnRegFile.sv ====
`default_nettype none

`include "nn_defines.svh"

module nnRegFile (
	input  bit                    CLOCK1_50,
	input  bit                    resetHidden,
	input  bit                    busWrite,
	input  nnBusPkg::regSelect    busSel,
	input  nnBusPkg::neuronIndex  busNeuron,
	input  nnBusPkg::busAddr      busAddr,
	input  nnBusPkg::busWord      busWriteData,
	output nnBusPkg::busWord      busReadData,
	output logic                  hiddenStart,
	output logic                  outputStart,
	output logic                  hiddenClear,
	output logic                  outputClear,
	input  nnMathPkg::layerSel    fetchLayer,
	input  nnBusPkg::busAddr      fetchIndex,
	output nnMathPkg::operandWord fetchInput,
	output nnMathPkg::operandWord fetchWeights [`HIDDEN_N],
	input  nnMathPkg::accumWord   hiddenResults [`HIDDEN_N],
	input  nnMathPkg::accumWord   outputResults [`OUTPUT_N],
	input  bit                    hiddenDone,
	input  bit                    outputDone
);
	import nnBusPkg::*;
	import nnMathPkg::*;

	localparam int InIdxW = $clog2(`INPUT_LEN);
	localparam int HidIdxW = $clog2(`HIDDEN_N);

	operandWord inputMem [`INPUT_LEN];
	operandWord hiddenWeightMem [`HIDDEN_N][`INPUT_LEN];
	operandWord outInputMem [`HIDDEN_N];
	operandWord outWeightMem [`OUTPUT_N][`HIDDEN_N];

	operandWord writeOperand;
	logic [InIdxW-1:0] inIdx;
	logic [HidIdxW-1:0] hidIdx;
	logic [InIdxW-1:0] fetchInIdx;
	logic [HidIdxW-1:0] fetchHidIdx;
	logic inInputRange;
	logic inHiddenRange;
	logic inOutputRange;
	logic inOutputRow;
	statusWord status;

	// Only the low operand bits of a write are kept
	assign writeOperand = busWriteData[`OPERAND_W-1:0];

	assign inIdx = busAddr[InIdxW-1:0];
	assign hidIdx = busAddr[HidIdxW-1:0];
	assign fetchInIdx = fetchIndex[InIdxW-1:0];
	assign fetchHidIdx = fetchIndex[HidIdxW-1:0];
	assign inInputRange = busAddr < `ADDR_W'(`INPUT_LEN);
	assign inHiddenRange = busAddr < `ADDR_W'(`HIDDEN_N);
	assign inOutputRange = busAddr < `ADDR_W'(`OUTPUT_N);
	assign inOutputRow = busNeuron < 2'(`OUTPUT_N);

	////////////////////
	// Host writes
	////////////////////

	always_ff @(posedge CLOCK1_50) begin
		if (busWrite) begin
			case (busSel)
				SEL_INPUT:
					if (inInputRange)
						inputMem[inIdx] <= writeOperand;
				SEL_HIDDEN_WEIGHT:
					if (inInputRange)
						hiddenWeightMem[busNeuron][inIdx] <= writeOperand;
				SEL_OUTPUT_INPUT:
					if (inHiddenRange)
						outInputMem[hidIdx] <= writeOperand;
				SEL_OUTPUT_WEIGHT:
					if (inHiddenRange && inOutputRow)
						outWeightMem[busNeuron][hidIdx] <= writeOperand;
				default: ;
			endcase
		end
	end

	// First element clears a layer, last element starts it
	always_ff @(posedge CLOCK1_50) begin
		if (resetHidden) begin
			hiddenClear <= 1'b0;
			hiddenStart <= 1'b0;
			outputClear <= 1'b0;
			outputStart <= 1'b0;
		end else begin
			hiddenClear <= busWrite && busSel == SEL_INPUT && busAddr == '0;
			hiddenStart <= busWrite && busSel == SEL_INPUT &&
				busAddr == `ADDR_W'(`INPUT_LEN - 1);
			outputClear <= busWrite && busSel == SEL_OUTPUT_INPUT && busAddr == '0;
			outputStart <= busWrite && busSel == SEL_OUTPUT_INPUT &&
				busAddr == `ADDR_W'(`HIDDEN_N - 1);
		end
	end

	////////////////////
	// Host reads
	////////////////////

	always_comb begin
		status = '0;
		status.hiddenDone = hiddenDone;
		status.outputDone = outputDone;
	end

	always_ff @(posedge CLOCK1_50) begin
		if (resetHidden) begin
			busReadData <= '0;
		end else if (!busWrite) begin
			busReadData <= '0;
			case (busSel)
				SEL_INPUT:
					if (inInputRange)
						busReadData <= busWord'(accumWord'(inputMem[inIdx]));
				SEL_OUTPUT_INPUT:
					if (inHiddenRange)
						busReadData <= busWord'(accumWord'(outInputMem[hidIdx]));
				SEL_HIDDEN_RESULT:
					if (inHiddenRange)
						busReadData <= busWord'(hiddenResults[hidIdx]);
				SEL_OUTPUT_RESULT:
					if (inOutputRange)
						busReadData <= busWord'(outputResults[hidIdx]);
				SEL_STATUS:
					busReadData <= busWord'(status);
				// Weight rows have no readback
				default: ;
			endcase
		end
	end

	// Operands for the sequencer
	assign fetchInput = (fetchLayer == LAYER_HIDDEN) ?
		inputMem[fetchInIdx] : outInputMem[fetchHidIdx];

	for (genvar n = 0; n < `HIDDEN_N; n++) begin : gFetchLane
		if (n < `OUTPUT_N) begin : gShared
			assign fetchWeights[n] = (fetchLayer == LAYER_HIDDEN) ?
				hiddenWeightMem[n][fetchInIdx] : outWeightMem[n][fetchHidIdx];
		end else begin : gHiddenOnly
			assign fetchWeights[n] = (fetchLayer == LAYER_HIDDEN) ?
				hiddenWeightMem[n][fetchInIdx] : '0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/nnMathPkg.sv ====
`default_nettype none

`include "nn_defines.svh"

package nnMathPkg;

	// Input element or weight
	typedef logic signed [`OPERAND_W-1:0] operandWord;

	// Running sum of one neuron, wraps at 2^32
	typedef logic signed [`ACCUM_W-1:0] accumWord;

	// Layer of a pass
	typedef enum logic {
		LAYER_HIDDEN = 1'b0,
		LAYER_OUTPUT = 1'b1
	} layerSel;

	// Sequencer states
	typedef enum logic {
		FETCH_IDLE = 1'b0,
		FETCH_RUN = 1'b1
	} fetchState;

endpackage

`default_nettype wire

// ==== verilog/nnBusPkg.sv ====
`default_nettype none

`include "nn_defines.svh"

package nnBusPkg;

	// Register picked by a host access
	typedef enum logic [2:0] {
		SEL_INPUT = 3'd0,
		SEL_HIDDEN_WEIGHT = 3'd1,
		SEL_OUTPUT_INPUT = 3'd2,
		SEL_OUTPUT_WEIGHT = 3'd3,
		SEL_HIDDEN_RESULT = 3'd4,
		SEL_OUTPUT_RESULT = 3'd5,
		SEL_STATUS = 3'd6
	} regSelect;

	// Element index inside a vector
	typedef logic [`ADDR_W-1:0] busAddr;

	// Weight row of one neuron
	typedef logic [1:0] neuronIndex;

	// Bus data word
	typedef logic [`ACCUM_W-1:0] busWord;

	// Status readback with the done flags in the low bits
	typedef struct packed {
		logic [`ACCUM_W-3:0] reserved;
		logic outputDone;
		logic hiddenDone;
	} statusWord;

endpackage

`default_nettype wire

// ==== verilog/nn_defines.svh ====
`ifndef NN_DEFINES_SVH
`define NN_DEFINES_SVH

////////////////////
// Layer sizes
////////////////////

// Hidden layer input vector length
`define INPUT_LEN 16

// Hidden neurons, also the number of MAC lanes
`define HIDDEN_N 4

// Output neurons on the low MAC lanes, never more than HIDDEN_N
`define OUTPUT_N 3

// Entries in the operand FIFO
`define FIFO_DEPTH 4

////////////////////
// Datapath widths
////////////////////

`define OPERAND_W 16
`define ACCUM_W 32
`define ADDR_W 8

`endif
